// File: hdl/sd_pkg.sv
// SD card SPI host shared types
// Command opcodes, response kinds, stage FSM states and the structs
// that carry commands, framed operations and results between stages

package sd_pkg;

  // Supported command indices
  typedef enum logic [5:0] {
    cmd0   = 6'd0,
    cmd8   = 6'd8,
    cmd17  = 6'd17,
    acmd41 = 6'd41,
    cmd55  = 6'd55,
    cmd58  = 6'd58
  } sd_opcode_e;

  typedef enum logic [1:0] {
    resp_r1       = 2'd0,
    resp_r7       = 2'd1,
    resp_r1_block = 2'd2
  } sd_resp_kind_e;

  typedef enum logic [2:0] {
    ok          = 3'd0,
    card_error  = 3'd1,
    crc_error   = 3'd2,
    timeout     = 3'd3,
    token_error = 3'd4
  } sd_status_e;

  typedef enum logic [1:0] {
    tx_idle,
    tx_shift,
    tx_hold
  } sd_tx_state_e;

  typedef enum logic [2:0] {
    rx_idle,
    rx_wait_start,
    rx_receiving,
    rx_wait_token,
    rx_block
  } sd_rx_state_e;

  typedef struct packed {
    sd_opcode_e  opcode;
    logic [31:0] argument;
    logic        read_block;
  } sd_cmd_t;

  typedef struct packed {
    logic [47:0]   frame;
    sd_resp_kind_e resp_kind;
  } sd_op_t;

  typedef struct packed {
    logic [7:0]  r1;
    logic [31:0] payload;
    logic        crc_bad;
    logic        timed_out;
    logic        got_block;
    logic        token_bad;
  } sd_rx_t;

  typedef struct packed {
    logic [7:0]  r1;
    logic [31:0] payload;
    sd_status_e  status;
    logic        block_valid;
    logic        illegal_cmd;
  } sd_result_t;

endpackage

// File: hdl/sd_cmd_decoder.sv
// SD command decoder
// Accepts one command while idle, builds the 48-bit frame with CRC7
// and picks the response kind the receiver must expect

`timescale 1ns/1ps

module sd_cmd_decoder (
  input  logic             clock,
  input  logic             reset,
  input  logic             cmd_valid,
  input  sd_pkg::sd_cmd_t  cmd,
  input  logic             done,
  output logic             busy,
  output logic             op_valid,
  output sd_pkg::sd_op_t   op
);

  logic                  accept;
  logic [39:0]           frame_body;
  logic [6:0]            crc;
  sd_pkg::sd_resp_kind_e kind;

  // CRC7, polynomial x^7 + x^3 + 1, MSB first
  function automatic logic [6:0] crc7(input logic [39:0] data);
    logic [6:0] c;
    logic       fb;
    c = 7'd0;
    for (int i = 39; i >= 0; i--) begin
      fb = c[6] ^ data[i];
      c = {c[5:0], 1'b0};
      if (fb) begin
        c = c ^ 7'h09;
      end
    end
    return c;
  endfunction

  assign accept = cmd_valid && !busy;

  // Start bit 0, transmission bit 1, then index and argument
  assign frame_body = {2'b01, cmd.opcode, cmd.argument};
  assign crc = crc7(frame_body);

  always_comb begin
    case (cmd.opcode)
      sd_pkg::cmd8, sd_pkg::cmd58: kind = sd_pkg::resp_r7;
      sd_pkg::cmd17: begin
        kind = cmd.read_block ? sd_pkg::resp_r1_block : sd_pkg::resp_r1;
      end
      default: kind = sd_pkg::resp_r1;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      busy <= 1'b0;
      op_valid <= 1'b0;
    end else begin
      op_valid <= accept;
      if (done) begin
        busy <= 1'b0;
      end else if (accept) begin
        busy <= 1'b1;
      end
    end
  end

  // Frame ends with CRC7 and the end bit
  always_ff @(posedge clock) begin
    if (accept) begin
      op.frame <= {frame_body, crc, 1'b1};
      op.resp_kind <= kind;
    end
  end

endmodule

// File: hdl/sd_cmd_transmitter.sv
// SD command transmitter
// Shifts the 48-bit command frame out on mosi, MSB first, and keeps
// chip select low until the whole operation is finished

`timescale 1ns/1ps

module sd_cmd_transmitter (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  op_valid,
  input  sd_pkg::sd_op_t        op,
  input  logic                  done,
  output logic                  cs_n,
  output logic                  mosi,
  output logic                  tx_done,
  output sd_pkg::sd_resp_kind_e resp_kind
);

  sd_pkg::sd_tx_state_e state;
  logic [47:0]          frame_sr;
  logic [5:0]           bit_cnt;
  logic                 load;

  assign load = (state == sd_pkg::tx_idle) && op_valid;

  // Line idles high whenever no frame bit is on it
  assign mosi = (state == sd_pkg::tx_shift) ? frame_sr[47] : 1'b1;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= sd_pkg::tx_idle;
      bit_cnt <= 6'd0;
      cs_n <= 1'b1;
      tx_done <= 1'b0;
    end else begin
      tx_done <= 1'b0;
      case (state)
        sd_pkg::tx_idle: begin
          if (op_valid) begin
            state <= sd_pkg::tx_shift;
            bit_cnt <= 6'd0;
            cs_n <= 1'b0;
          end
        end
        sd_pkg::tx_shift: begin
          if (bit_cnt == 6'd47) begin
            state <= sd_pkg::tx_hold;
            tx_done <= 1'b1;
          end else begin
            bit_cnt <= bit_cnt + 6'd1;
          end
        end
        sd_pkg::tx_hold: begin
          // Card stays selected through the response
          if (done) begin
            state <= sd_pkg::tx_idle;
            cs_n <= 1'b1;
          end
        end
        default: begin
          state <= sd_pkg::tx_idle;
          cs_n <= 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      frame_sr <= op.frame;
      resp_kind <= op.resp_kind;
    end else if (state == sd_pkg::tx_shift) begin
      frame_sr <= {frame_sr[46:0], 1'b0};
    end
  end

endmodule

// File: hdl/sd_receiver.sv
// SD response receiver
// Waits for the card's start bit, collects R1 or R7, and for block reads
// waits for the data token, shifts in 4096 data bits and checks the CRC16.
// Raises timed_out when miso stays high too long in any wait

`timescale 1ns/1ps

module sd_receiver #(
  parameter int resp_timeout = 64
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  tx_done,
  input  sd_pkg::sd_resp_kind_e resp_kind,
  input  logic                  miso,
  output logic                  rx_done,
  output sd_pkg::sd_rx_t        rx,
  output logic [4095:0]         rx_block
);

  localparam int wait_w = $clog2(resp_timeout + 1);
  localparam logic [wait_w-1:0] wait_last = wait_w'(resp_timeout - 1);
  localparam logic [wait_w-1:0] token_ones = wait_w'(7);
  // 4096 data bits plus 16 CRC bits, counted down to zero
  localparam logic [12:0] block_last = 13'd4111;

  sd_pkg::sd_rx_state_e state;
  logic [12:0]          bit_cnt;
  logic [wait_w-1:0]    wait_cnt;
  logic [39:0]          resp_sr;
  logic [39:0]          resp_next;
  logic [15:0]          crc;
  logic [15:0]          crc_next;
  logic                 resp_shift;
  logic                 data_shift;

  assign resp_next = {resp_sr[38:0], miso};
  assign resp_shift = ((state == sd_pkg::rx_wait_start) && !miso) ||
                      (state == sd_pkg::rx_receiving);
  // Data register freezes once the CRC bits start
  assign data_shift = (state == sd_pkg::rx_block) && (bit_cnt > 13'd15);

  // CRC16-CCITT, polynomial 0x1021
  always_comb begin
    crc_next = {crc[14:0], 1'b0};
    if (crc[15] ^ miso) begin
      crc_next = crc_next ^ 16'h1021;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= sd_pkg::rx_idle;
      bit_cnt <= 13'd0;
      wait_cnt <= '0;
      crc <= 16'd0;
      rx_done <= 1'b0;
      rx <= '0;
    end else begin
      rx_done <= 1'b0;
      case (state)
        sd_pkg::rx_idle: begin
          if (tx_done) begin
            state <= sd_pkg::rx_wait_start;
            wait_cnt <= '0;
            rx <= '0;
          end
        end
        sd_pkg::rx_wait_start: begin
          if (!miso) begin
            // Start bit already shifted in, count the rest
            state <= sd_pkg::rx_receiving;
            bit_cnt <= (resp_kind == sd_pkg::resp_r7) ? 13'd38 : 13'd6;
          end else if (wait_cnt == wait_last) begin
            rx.timed_out <= 1'b1;
            rx_done <= 1'b1;
            state <= sd_pkg::rx_idle;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        sd_pkg::rx_receiving: begin
          if (bit_cnt == 13'd0) begin
            if (resp_kind == sd_pkg::resp_r7) begin
              rx.r1 <= resp_next[39:32];
              rx.payload <= resp_next[31:0];
            end else begin
              rx.r1 <= resp_next[7:0];
            end
            // Data only follows a clean R1
            if (resp_kind == sd_pkg::resp_r1_block && resp_next[7:0] == 8'h00) begin
              state <= sd_pkg::rx_wait_token;
              wait_cnt <= '0;
            end else begin
              rx_done <= 1'b1;
              state <= sd_pkg::rx_idle;
            end
          end else begin
            bit_cnt <= bit_cnt - 13'd1;
          end
        end
        sd_pkg::rx_wait_token: begin
          // wait_cnt doubles as the count of ones seen before the zero
          if (!miso) begin
            if (wait_cnt < token_ones) begin
              rx.token_bad <= 1'b1;
              rx_done <= 1'b1;
              state <= sd_pkg::rx_idle;
            end else begin
              state <= sd_pkg::rx_block;
              bit_cnt <= block_last;
              crc <= 16'd0;
            end
          end else if (wait_cnt == wait_last) begin
            rx.timed_out <= 1'b1;
            rx_done <= 1'b1;
            state <= sd_pkg::rx_idle;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        sd_pkg::rx_block: begin
          crc <= crc_next;
          if (bit_cnt == 13'd0) begin
            // Remainder over data plus CRC is zero when intact
            rx.got_block <= 1'b1;
            rx.crc_bad <= (crc_next != 16'd0);
            rx_done <= 1'b1;
            state <= sd_pkg::rx_idle;
          end else begin
            bit_cnt <= bit_cnt - 13'd1;
          end
        end
        default: state <= sd_pkg::rx_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (resp_shift) begin
      resp_sr <= resp_next;
    end
    if (data_shift) begin
      rx_block <= {rx_block[4094:0], miso};
    end
  end

endmodule

// File: hdl/sd_result_collector.sv
// SD result collector
// Classifies the receiver outcome, registers result and block
// and pulses done for one cycle

`timescale 1ns/1ps

module sd_result_collector (
  input  logic               clock,
  input  logic               reset,
  input  logic               rx_done,
  input  sd_pkg::sd_rx_t     rx,
  input  logic [4095:0]      rx_block,
  output logic               done,
  output sd_pkg::sd_result_t result,
  output logic [4095:0]      block
);

  sd_pkg::sd_status_e status;

  // Highest priority first; R1 idle bit alone is not an error
  always_comb begin
    if (rx.timed_out) begin
      status = sd_pkg::timeout;
    end else if (rx.r1[7:1] != 7'd0) begin
      status = sd_pkg::card_error;
    end else if (rx.token_bad) begin
      status = sd_pkg::token_error;
    end else if (rx.crc_bad) begin
      status = sd_pkg::crc_error;
    end else begin
      status = sd_pkg::ok;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= rx_done;
    end
  end

  always_ff @(posedge clock) begin
    if (rx_done) begin
      result.r1 <= rx.r1;
      result.payload <= rx.payload;
      result.status <= status;
      result.block_valid <= rx.got_block;
      result.illegal_cmd <= rx.r1[2];
      // Zeros when no block came back
      block <= rx.got_block ? rx_block : '0;
    end
  end

endmodule

// File: hdl/sd_spi_host.sv
// SD card SPI host, command and response path
// Decode, execute (transmit and receive) and result stages in a chain

`timescale 1ns/1ps

module sd_spi_host #(
  parameter int resp_timeout = 64
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               cmd_valid,
  input  sd_pkg::sd_cmd_t    cmd,
  output logic               busy,
  output logic               done,
  output sd_pkg::sd_result_t result,
  output logic [4095:0]      block,
  output logic               cs_n,
  output logic               mosi,
  input  logic               miso
);

  logic                  op_valid;
  sd_pkg::sd_op_t        op;
  logic                  tx_done;
  sd_pkg::sd_resp_kind_e resp_kind;
  logic                  rx_done;
  sd_pkg::sd_rx_t        rx;
  logic [4095:0]         rx_block;

  sd_cmd_decoder decoder0 (
    .clock     (clock),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .done      (done),
    .busy      (busy),
    .op_valid  (op_valid),
    .op        (op)
  );

  sd_cmd_transmitter transmitter0 (
    .clock     (clock),
    .reset     (reset),
    .op_valid  (op_valid),
    .op        (op),
    .done      (done),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .tx_done   (tx_done),
    .resp_kind (resp_kind)
  );

  sd_receiver #(
    .resp_timeout (resp_timeout)
  ) receiver0 (
    .clock     (clock),
    .reset     (reset),
    .tx_done   (tx_done),
    .resp_kind (resp_kind),
    .miso      (miso),
    .rx_done   (rx_done),
    .rx        (rx),
    .rx_block  (rx_block)
  );

  sd_result_collector collector0 (
    .clock    (clock),
    .reset    (reset),
    .rx_done  (rx_done),
    .rx       (rx),
    .rx_block (rx_block),
    .done     (done),
    .result   (result),
    .block    (block)
  );

endmodule

// File: dv/sd_assertions.sv
// SD SPI host protocol assertions
// Chip select, mosi idle level and done pulse, bound into the top level

`timescale 1ns/1ps

module sd_assertions (
  input logic clock,
  input logic reset,
  input logic busy,
  input logic done,
  input logic cs_n,
  input logic mosi
);

  int failures = 0;

  // Card is selected only during an operation
  cs_idle: assert property (@(posedge clock) disable iff (reset) !busy |-> cs_n)
    else begin
      $error("cs_n low while busy is low");
      failures++;
    end

  done_pulse: assert property (@(posedge clock) disable iff (reset) done |=> !done)
    else begin
      $error("done high for more than one cycle");
      failures++;
    end

  done_busy: assert property (@(posedge clock) disable iff (reset) done |-> busy)
    else begin
      $error("done without an operation in progress");
      failures++;
    end

  // Line idles high when deselected
  mosi_idle: assert property (@(posedge clock) disable iff (reset) cs_n |-> mosi)
    else begin
      $error("mosi low while cs_n is high");
      failures++;
    end

endmodule

bind sd_spi_host sd_assertions asrt0 (
  .clock (clock),
  .reset (reset),
  .busy  (busy),
  .done  (done),
  .cs_n  (cs_n),
  .mosi  (mosi)
);

// File: dv/sd_monitor.sv
// SD SPI host result checker
// Pops the expected result on each done and compares it with the DUT,
// along with the command frame the card model captured

`timescale 1ns/1ps

module sd_monitor (
  input logic               clock,
  input logic               reset,
  input logic               done,
  input sd_pkg::sd_result_t result,
  input logic [4095:0]      block
);

  sd_pkg::sd_cmd_t    cmd_q[$];
  logic [47:0]        frame_q[$];
  sd_pkg::sd_result_t result_q[$];
  logic [4095:0]      block_q[$];
  int                 test_count = 0;
  int                 pass_count = 0;
  int                 fail_count = 0;

  // CRC7 with x^7 + x^3 + 1 over start, transmit, index and argument
  function automatic logic [6:0] crc7_of(input logic [39:0] bits);
    logic [6:0] c;
    logic       fb;
    c = 7'd0;
    for (int i = 39; i >= 0; i--) begin
      fb = c[6] ^ bits[i];
      c = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return c;
  endfunction

  function automatic int pending();
    return result_q.size();
  endfunction

  task automatic push_expected(input sd_pkg::sd_cmd_t c, input logic [47:0] frame,
                               input sd_pkg::sd_result_t r, input logic [4095:0] b);
    cmd_q.push_back(c);
    frame_q.push_back(frame);
    result_q.push_back(r);
    block_q.push_back(b);
  endtask

  task automatic compare_field(input string what, input logic [31:0] got,
                               input logic [31:0] want, inout int errors);
    if (got !== want) begin
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, want);
      errors++;
    end
  endtask

  task automatic check_result();
    sd_pkg::sd_cmd_t    c;
    sd_pkg::sd_result_t want;
    logic [47:0]        frame;
    logic [47:0]        frame_want;
    logic [4095:0]      want_block;
    int                 errors;
    errors = 0;
    test_count++;
    if (result_q.size() == 0) begin
      $display("Done arrived at %0t with no command outstanding", $time);
      fail_count++;
    end else begin
      c = cmd_q.pop_front();
      frame = frame_q.pop_front();
      want = result_q.pop_front();
      want_block = block_q.pop_front();
      frame_want = {2'b01, c.opcode, c.argument, 7'd0, 1'b1};
      frame_want[7:1] = crc7_of(frame_want[47:8]);
      if (frame !== frame_want) begin
        $display("Error at %0t: frame %h, expected %h", $time, frame, frame_want);
        errors++;
      end
      compare_field("r1", result.r1, want.r1, errors);
      compare_field("payload", result.payload, want.payload, errors);
      compare_field("status", result.status, want.status, errors);
      compare_field("block_valid", result.block_valid, want.block_valid, errors);
      compare_field("illegal_cmd", result.illegal_cmd, want.illegal_cmd, errors);
      if (block !== want_block) begin
        $display("Error at %0t: block data differs from the data sent", $time);
        errors++;
      end
      if (errors == 0) begin
        pass_count++;
        $display("Test %0d CMD%0d %s passed", test_count, c.opcode, want.status.name());
      end else begin
        fail_count++;
        $display("Test %0d CMD%0d %s failed", test_count, c.opcode, want.status.name());
      end
    end
  endtask

  always @(posedge clock) begin
    if (!reset && done) begin
      check_result();
    end
  end

endmodule

// File: dv/sd_tb.sv
// SD SPI host testbench
// Random commands from an xorshift source, a behavioural SPI-mode card on
// cs_n, mosi and miso, and expected results handed to the monitor

`timescale 1ns/1ps

module sd_tb;

  localparam int resp_timeout = 64;
  localparam int num_tests = 60;

  logic               clock;
  logic               reset;
  logic               cmd_valid;
  sd_pkg::sd_cmd_t    cmd;
  logic               busy;
  logic               done;
  sd_pkg::sd_result_t result;
  logic [4095:0]      block;
  logic               cs_n;
  logic               mosi;
  logic               miso;

  logic [31:0] rng_state;
  logic        aborted;
  logic        extra_frame;
  int          issued;

  sd_spi_host #(
    .resp_timeout (resp_timeout)
  ) dut0 (
    .clock     (clock),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .busy      (busy),
    .done      (done),
    .result    (result),
    .block     (block),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso)
  );

  sd_monitor mon0 (
    .clock  (clock),
    .reset  (reset),
    .done   (done),
    .result (result),
    .block  (block)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic sd_pkg::sd_opcode_e pick_opcode(input logic [31:0] r);
    case (r[2:0])
      3'd0: return sd_pkg::cmd0;
      3'd1: return sd_pkg::cmd8;
      3'd2, 3'd3, 3'd4: return sd_pkg::cmd17;
      3'd5: return sd_pkg::cmd55;
      3'd6: return sd_pkg::cmd58;
      default: return sd_pkg::acmd41;
    endcase
  endfunction

  // Mostly clean answers, sometimes idle or error bits; MSB is the start bit
  function automatic logic [7:0] pick_r1(input logic [31:0] r);
    case (r[2:0])
      3'd5: return 8'h01;
      3'd6, 3'd7: return {1'b0, r[14:8]};
      default: return 8'h00;
    endcase
  endfunction

  // CRC16-CCITT over the data block, MSB first, zero initial value
  function automatic logic [15:0] crc16_of(input logic [4095:0] data);
    logic [15:0] c;
    logic        fb;
    c = 16'd0;
    for (int i = 4095; i >= 0; i--) begin
      fb = c[15] ^ data[i];
      c = {c[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
    end
    return c;
  endfunction

  task automatic send_bit(input logic b);
    @(posedge clock);
    miso <= b;
  endtask

  task automatic send_bits(input logic [63:0] bits, input int count);
    for (int i = count - 1; i >= 0; i--) begin
      send_bit(bits[i]);
    end
  endtask

  // Card side: waits for the start bit, then shifts in the whole frame
  task automatic receive_frame(output logic [47:0] frame, output logic ok);
    int count;
    int waited;
    frame = '0;
    count = 0;
    waited = 0;
    while (count < 48 && waited < 200) begin
      @(posedge clock);
      waited++;
      if (!cs_n && (count > 0 || !mosi)) begin
        frame = {frame[46:0], mosi};
        count++;
      end
    end
    ok = (count == 48);
  endtask

  task automatic strobe_while_busy(input sd_pkg::sd_cmd_t c);
    @(posedge clock);
    cmd_valid <= 1'b1;
    cmd <= c;
    @(posedge clock);
    cmd_valid <= 1'b0;
  endtask

  task automatic wait_done(input int limit, output logic ok);
    int waited;
    ok = 1'b0;
    waited = 0;
    while (!ok && waited < limit) begin
      @(posedge clock);
      waited++;
      ok = done;
    end
  endtask

  initial begin
    sd_pkg::sd_cmd_t       c;
    sd_pkg::sd_cmd_t       stray;
    sd_pkg::sd_resp_kind_e kind;
    sd_pkg::sd_result_t    want;
    logic [4095:0]         want_block;
    logic [4095:0]         data;
    logic [47:0]           frame;
    logic [7:0]            r1v;
    logic [31:0]           trailer;
    logic [15:0]           crc;
    logic                  ok;
    logic                  extra;
    int                    fault;
    int                    delay;
    int                    ones;
    rng_state = 32'd97;
    aborted = 1'b0;
    extra_frame = 1'b0;
    issued = 0;
    reset = 1'b1;
    cmd_valid = 1'b0;
    cmd = '0;
    miso = 1'b1;
    repeat (10) @(posedge clock);
    reset <= 1'b0;

    for (int t = 0; t < num_tests && !aborted; t++) begin
      c.opcode = pick_opcode(next_random());
      c.argument = next_random();
      c.read_block = (next_random() % 4) != 0;
      // 0 silent card, 1 corrupted CRC16, 2 early token zero
      fault = next_random() % 6;
      r1v = pick_r1(next_random());
      trailer = next_random();
      delay = 1 + next_random() % 20;
      extra = (next_random() % 4) == 0;
      stray = c;
      stray.argument = ~c.argument;
      if (c.opcode == sd_pkg::cmd8 || c.opcode == sd_pkg::cmd58) begin
        kind = sd_pkg::resp_r7;
      end else if (c.opcode == sd_pkg::cmd17 && c.read_block) begin
        kind = sd_pkg::resp_r1_block;
      end else begin
        kind = sd_pkg::resp_r1;
      end
      for (int w = 0; w < 128; w++) begin
        data[w*32 +: 32] = next_random();
      end
      crc = crc16_of(data);
      if (fault == 1) begin
        crc = crc ^ (16'h0001 << (next_random() % 16));
      end

      // Expected outcome by the classification rules
      want = '0;
      want_block = '0;
      if (fault == 0) begin
        want.status = sd_pkg::timeout;
      end else begin
        want.r1 = r1v;
        want.illegal_cmd = r1v[2];
        if (kind == sd_pkg::resp_r7) begin
          want.payload = trailer;
        end
        if (r1v[7:1] != 7'd0) begin
          want.status = sd_pkg::card_error;
        end else if (kind == sd_pkg::resp_r1_block && r1v == 8'h00) begin
          if (fault == 2) begin
            want.status = sd_pkg::token_error;
          end else begin
            want.block_valid = 1'b1;
            want_block = data;
            want.status = (fault == 1) ? sd_pkg::crc_error : sd_pkg::ok;
          end
        end else begin
          want.status = sd_pkg::ok;
        end
      end

      @(posedge clock);
      cmd_valid <= 1'b1;
      cmd <= c;
      @(posedge clock);
      cmd_valid <= 1'b0;
      issued++;
      fork
        receive_frame(frame, ok);
        begin
          if (extra) begin
            strobe_while_busy(stray);
          end
        end
      join

      if (!ok) begin
        $display("Card model got no complete command frame in test %0d", t);
        aborted = 1'b1;
      end else begin
        mon0.push_expected(c, frame, want, want_block);
        if (fault != 0) begin
          repeat (delay - 1) @(posedge clock);
          if (kind == sd_pkg::resp_r7) begin
            send_bits({r1v, trailer}, 40);
          end else begin
            send_bits(r1v, 8);
          end
          if (kind == sd_pkg::resp_r1_block && r1v == 8'h00) begin
            if (fault == 2) begin
              // Fewer than seven ones before the zero
              ones = next_random() % 7;
              send_bits(((64'd1 << ones) - 1) << 1, ones + 1);
            end else begin
              repeat (delay % 8) send_bit(1'b1);
              send_bits(8'hfe, 8);
              for (int i = 4095; i >= 0; i--) begin
                send_bit(data[i]);
              end
              send_bits(crc, 16);
            end
          end
          @(posedge clock);
          miso <= 1'b1;
        end
        wait_done((fault == 0) ? resp_timeout + 8 : 6000, ok);
        if (!ok) begin
          $display("DUT gave no done within the wait limit in test %0d", t);
          aborted = 1'b1;
        end
      end
    end

    // No frame may follow the last result
    repeat (60) begin
      @(posedge clock);
      if (!cs_n) begin
        extra_frame = 1'b1;
      end
    end
    if (extra_frame) begin
      $display("Chip select went low with no command outstanding");
    end
    $display("Summary: %0d issued, %0d checked, %0d passed, %0d failed",
             issued, mon0.test_count, mon0.pass_count, mon0.fail_count);
    if (!aborted && !extra_frame && mon0.fail_count == 0 && mon0.pending() == 0 &&
        mon0.test_count == issued && dut0.asrt0.failures == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: vlog.f
hdl/sd_pkg.sv
hdl/sd_cmd_decoder.sv
hdl/sd_cmd_transmitter.sv
hdl/sd_receiver.sv
hdl/sd_result_collector.sv
hdl/sd_spi_host.sv
dv/sd_assertions.sv
dv/sd_monitor.sv
dv/sd_tb.sv
